// ==== source/wr_guard_pkg.sv ====
// Write guard package: width typedefs, bus, config, event, timeout and status structs, enums
package wr_guard_pkg;

  // Widths with a meaning on the write channel
  typedef logic [3:0]  id_t;
  typedef logic [7:0]  len_t;
  typedef logic [11:0] cnt_t;

  // Manager side of the write channel
  typedef struct packed {
    logic aw_valid;
    id_t  aw_id;
    len_t aw_len;
    logic w_valid;
    logic w_last;
    logic b_ready;
  } wr_req_t;

  // Subordinate side of the write channel
  typedef struct packed {
    logic aw_ready;
    logic w_ready;
    logic b_valid;
    id_t  b_id;
  } wr_rsp_t;

  // Cycle budgets, W budget is per beat
  typedef struct packed {
    cnt_t budget_aw;
    cnt_t budget_w_unit;
    cnt_t budget_b;
  } budget_cfg_t;

  // One-cycle event pulses seen by the tracker
  typedef struct packed {
    logic aw_start;
    logic aw_done;
    id_t  aw_id;
    len_t aw_len;
    logic w_beat;
    logic w_last;
    logic b_done;
    id_t  b_id;
  } wr_event_t;

  typedef enum logic [1:0] {
    PH_FREE = 2'd0,
    PH_AW   = 2'd1,
    PH_W    = 2'd2,
    PH_B    = 2'd3
  } phase_e;

  typedef enum logic {
    GS_MONITOR   = 1'b0,
    GS_RESET_REQ = 1'b1
  } guard_state_e;

  typedef struct packed {
    logic   valid;
    id_t    id;
    phase_e phase;
  } timeout_t;

  typedef struct packed {
    logic [4:0] outstanding;
    logic       overflow;
    id_t        last_id;
    phase_e     last_phase;
    logic [7:0] timeout_cnt;
  } guard_status_t;

endpackage

// ==== source/wr_event_decode.sv ====
// Write channel event decoder: handshake detection and registered event pulses
`timescale 1ns/1ps

module wr_event_decode (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  wr_guard_pkg::wr_req_t   mst_req_i,
  input  wr_guard_pkg::wr_rsp_t   slv_rsp_i,
  output wr_guard_pkg::wr_event_t evt_o
);
  import wr_guard_pkg::*;

  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic aw_new;

  // AW request seen but not yet accepted
  logic aw_pending_q;

  logic aw_start_q;
  logic aw_done_q;
  logic w_beat_q;
  logic w_last_q;
  logic b_done_q;

  id_t  aw_id_q;
  len_t aw_len_q;
  id_t  b_id_q;

  assign aw_hs = mst_req_i.aw_valid && slv_rsp_i.aw_ready;
  assign w_hs  = mst_req_i.w_valid && slv_rsp_i.w_ready;
  assign b_hs  = slv_rsp_i.b_valid && mst_req_i.b_ready;

  // A held aw_valid only counts once
  assign aw_new = mst_req_i.aw_valid && !aw_pending_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      aw_pending_q <= 1'b0;
      aw_start_q   <= 1'b0;
      aw_done_q    <= 1'b0;
      w_beat_q     <= 1'b0;
      w_last_q     <= 1'b0;
      b_done_q     <= 1'b0;
    end else begin
      aw_pending_q <= mst_req_i.aw_valid && !slv_rsp_i.aw_ready;
      aw_start_q   <= aw_new;
      aw_done_q    <= aw_hs;
      w_beat_q     <= w_hs;
      // Qualifier only, valid together with w_beat
      w_last_q     <= mst_req_i.w_last;
      b_done_q     <= b_hs;
    end
  end

  // Payload rides along with the pulses
  always_ff @(posedge clk_i) begin
    aw_id_q  <= mst_req_i.aw_id;
    aw_len_q <= mst_req_i.aw_len;
    b_id_q   <= slv_rsp_i.b_id;
  end

  assign evt_o.aw_start = aw_start_q;
  assign evt_o.aw_done  = aw_done_q;
  assign evt_o.aw_id    = aw_id_q;
  assign evt_o.aw_len   = aw_len_q;
  assign evt_o.w_beat   = w_beat_q;
  assign evt_o.w_last   = w_last_q;
  assign evt_o.b_done   = b_done_q;
  assign evt_o.b_id     = b_id_q;

endmodule

// ==== source/wr_txn_tracker.sv ====
// Outstanding write table, AW and W order queues, phase counters and timeout detection
`timescale 1ns/1ps

module wr_txn_tracker #(
  parameter int unsigned MaxTxns = 8
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  wr_guard_pkg::wr_event_t   evt_i,
  input  wr_guard_pkg::budget_cfg_t budget_i,
  input  logic                      flush_i,
  output wr_guard_pkg::timeout_t    timeout_o,
  output logic [4:0]                outstanding_o,
  output logic                      overflow_o
);
  import wr_guard_pkg::*;

  localparam int unsigned IdxWidth = (MaxTxns > 1) ? $clog2(MaxTxns) : 1;
  // Wide enough for budget_w_unit * 256 beats
  localparam int unsigned BudgetWidth = $bits(cnt_t) + $bits(len_t) + 1;

  typedef logic [IdxWidth-1:0]    idx_t;
  typedef logic [IdxWidth:0]      qcnt_t;
  typedef logic [BudgetWidth-1:0] budget_t;

  typedef struct packed {
    phase_e phase;
    id_t    id;
    len_t   len;
    cnt_t   cnt;
  } entry_t;

  entry_t   entry_d [MaxTxns];
  entry_t   entry_q [MaxTxns];

  // Entry indices in AW order, then in AW acceptance order
  idx_t     aw_fifo_d [MaxTxns];
  idx_t     aw_fifo_q [MaxTxns];
  idx_t     w_fifo_d  [MaxTxns];
  idx_t     w_fifo_q  [MaxTxns];
  idx_t     aw_head_d, aw_head_q, aw_tail_d, aw_tail_q;
  idx_t     w_head_d, w_head_q, w_tail_d, w_tail_q;
  qcnt_t    aw_cnt_d, aw_cnt_q, w_cnt_d, w_cnt_q;

  logic     overflow_d, overflow_q;
  timeout_t timeout_d, timeout_q;

  logic     free_found;
  idx_t     free_idx;
  logic     b_found;
  idx_t     b_idx;
  idx_t     aw_pop_idx;
  idx_t     w_pop_idx;
  logic [4:0] outstanding;

  function automatic idx_t ptr_inc(input idx_t p);
    if (p == idx_t'(MaxTxns - 1)) begin
      return '0;
    end
    return p + idx_t'(1);
  endfunction

  function automatic budget_t phase_budget(input entry_t e, input budget_cfg_t b);
    logic [8:0] beats;
    beats = {1'b0, e.len} + 9'd1;
    case (e.phase)
      PH_AW:   return budget_t'(b.budget_aw);
      PH_W:    return budget_t'(b.budget_w_unit) * budget_t'(beats);
      PH_B:    return budget_t'(b.budget_b);
      default: return '1;
    endcase
  endfunction

  // Lowest free slot and lowest PH_B slot matching the B ID
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    b_found    = 1'b0;
    b_idx      = '0;
    for (int i = MaxTxns - 1; i >= 0; i--) begin
      if (entry_q[i].phase == PH_FREE) begin
        free_found = 1'b1;
        free_idx   = idx_t'(i);
      end
      if (entry_q[i].phase == PH_B && entry_q[i].id == evt_i.b_id) begin
        b_found = 1'b1;
        b_idx   = idx_t'(i);
      end
    end
  end

  // Events are applied in bus order so same-cycle AW and W chains resolve
  always_comb begin
    entry_d    = entry_q;
    aw_fifo_d  = aw_fifo_q;
    w_fifo_d   = w_fifo_q;
    aw_head_d  = aw_head_q;
    aw_tail_d  = aw_tail_q;
    aw_cnt_d   = aw_cnt_q;
    w_head_d   = w_head_q;
    w_tail_d   = w_tail_q;
    w_cnt_d    = w_cnt_q;
    overflow_d = overflow_q;
    aw_pop_idx = '0;
    w_pop_idx  = '0;

    // Saturating per-entry phase counters
    for (int i = 0; i < MaxTxns; i++) begin
      if (entry_q[i].phase != PH_FREE && entry_q[i].cnt != '1) begin
        entry_d[i].cnt = entry_q[i].cnt + cnt_t'(1);
      end
    end

    if (flush_i) begin
      for (int i = 0; i < MaxTxns; i++) begin
        entry_d[i].phase = PH_FREE;
        entry_d[i].cnt   = '0;
      end
      aw_head_d  = '0;
      aw_tail_d  = '0;
      aw_cnt_d   = '0;
      w_head_d   = '0;
      w_tail_d   = '0;
      w_cnt_d    = '0;
      overflow_d = 1'b0;
    end else begin
      if (evt_i.b_done && b_found) begin
        entry_d[b_idx].phase = PH_FREE;
        entry_d[b_idx].cnt   = '0;
      end
      if (evt_i.aw_start) begin
        if (free_found) begin
          entry_d[free_idx] = '{phase: PH_AW, id: evt_i.aw_id, len: evt_i.aw_len,
                                cnt: cnt_t'(0)};
          aw_fifo_d[aw_tail_d] = free_idx;
          aw_tail_d = ptr_inc(aw_tail_d);
          aw_cnt_d  = aw_cnt_d + qcnt_t'(1);
        end else begin
          overflow_d = 1'b1;
        end
      end
      // Dropped AWs leave the queue empty here
      if (evt_i.aw_done && aw_cnt_d != '0) begin
        aw_pop_idx = aw_fifo_d[aw_head_d];
        aw_head_d  = ptr_inc(aw_head_d);
        aw_cnt_d   = aw_cnt_d - qcnt_t'(1);
        entry_d[aw_pop_idx].phase = PH_W;
        entry_d[aw_pop_idx].cnt   = '0;
        w_fifo_d[w_tail_d] = aw_pop_idx;
        w_tail_d = ptr_inc(w_tail_d);
        w_cnt_d  = w_cnt_d + qcnt_t'(1);
      end
      if (evt_i.w_beat && evt_i.w_last && w_cnt_d != '0) begin
        w_pop_idx = w_fifo_d[w_head_d];
        w_head_d  = ptr_inc(w_head_d);
        w_cnt_d   = w_cnt_d - qcnt_t'(1);
        entry_d[w_pop_idx].phase = PH_B;
        entry_d[w_pop_idx].cnt   = '0;
      end
    end
  end

  // Lowest-index entry over its phase budget
  always_comb begin
    timeout_d = '0;
    for (int i = MaxTxns - 1; i >= 0; i--) begin
      if (entry_q[i].phase != PH_FREE &&
          budget_t'(entry_q[i].cnt) > phase_budget(entry_q[i], budget_i)) begin
        timeout_d.valid = 1'b1;
        timeout_d.id    = entry_q[i].id;
        timeout_d.phase = entry_q[i].phase;
      end
    end
    if (flush_i) begin
      timeout_d = '0;
    end
  end

  always_comb begin
    outstanding = '0;
    for (int i = 0; i < MaxTxns; i++) begin
      if (entry_q[i].phase != PH_FREE) begin
        outstanding = outstanding + 5'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MaxTxns; i++) begin
        entry_q[i] <= '0;
      end
      aw_head_q  <= '0;
      aw_tail_q  <= '0;
      aw_cnt_q   <= '0;
      w_head_q   <= '0;
      w_tail_q   <= '0;
      w_cnt_q    <= '0;
      overflow_q <= 1'b0;
      timeout_q  <= '0;
    end else begin
      entry_q    <= entry_d;
      aw_head_q  <= aw_head_d;
      aw_tail_q  <= aw_tail_d;
      aw_cnt_q   <= aw_cnt_d;
      w_head_q   <= w_head_d;
      w_tail_q   <= w_tail_d;
      w_cnt_q    <= w_cnt_d;
      overflow_q <= overflow_d;
      timeout_q  <= timeout_d;
    end
  end

  // Queue storage
  always_ff @(posedge clk_i) begin
    aw_fifo_q <= aw_fifo_d;
    w_fifo_q  <= w_fifo_d;
  end

  assign timeout_o     = timeout_q;
  assign outstanding_o = outstanding;
  assign overflow_o    = overflow_q;

endmodule

// ==== source/wr_timeout_handler.sv ====
// Timeout handler: reset request FSM, interrupt, timeout record and count, status assembly
`timescale 1ns/1ps

module wr_timeout_handler (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  wr_guard_pkg::timeout_t      timeout_i,
  input  logic                        reset_clear_i,
  input  logic [4:0]                  outstanding_i,
  input  logic                        overflow_i,
  output logic                        flush_o,
  output logic                        reset_req_o,
  output logic                        irq_o,
  output wr_guard_pkg::guard_status_t status_o
);
  import wr_guard_pkg::*;

  guard_state_e state_d, state_q;

  // Record of the timeout that caused the reset request
  id_t          last_id_q;
  phase_e       last_phase_q;
  logic [7:0]   timeout_cnt_q;

  logic         capture;

  // Only the first timeout while monitoring is recorded
  assign capture = (state_q == GS_MONITOR) && timeout_i.valid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      GS_MONITOR: begin
        if (timeout_i.valid) begin
          state_d = GS_RESET_REQ;
        end
      end
      GS_RESET_REQ: begin
        if (reset_clear_i) begin
          state_d = GS_MONITOR;
        end
      end
      default: state_d = GS_MONITOR;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q       <= GS_MONITOR;
      last_id_q     <= '0;
      last_phase_q  <= PH_FREE;
      timeout_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (capture) begin
        last_id_q    <= timeout_i.id;
        last_phase_q <= timeout_i.phase;
        // Saturates rather than wrapping back to zero
        if (timeout_cnt_q != '1) begin
          timeout_cnt_q <= timeout_cnt_q + 8'd1;
        end
      end
    end
  end

  // Table flush lasts as long as the reset request
  assign flush_o     = (state_q == GS_RESET_REQ);
  assign reset_req_o = (state_q == GS_RESET_REQ);
  assign irq_o       = (state_q == GS_RESET_REQ);

  assign status_o.outstanding = outstanding_i;
  assign status_o.overflow    = overflow_i;
  assign status_o.last_id     = last_id_q;
  assign status_o.last_phase  = last_phase_q;
  assign status_o.timeout_cnt = timeout_cnt_q;

endmodule

// ==== source/write_guard.sv ====
// Write guard top level: event decoder, transaction tracker and timeout handler
`timescale 1ns/1ps

module write_guard #(
  // Table depth, 2 to 16
  parameter int unsigned MaxTxns = 8
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  wr_guard_pkg::wr_req_t       mst_req_i,
  input  wr_guard_pkg::wr_rsp_t       slv_rsp_i,
  input  wr_guard_pkg::budget_cfg_t   budget_i,
  input  logic                        reset_clear_i,
  output logic                        reset_req_o,
  output logic                        irq_o,
  output wr_guard_pkg::guard_status_t status_o
);
  import wr_guard_pkg::*;

  wr_event_t  evt;
  timeout_t   timeout;
  logic       flush;
  logic [4:0] outstanding;
  logic       overflow;

  // Bus handshakes to event pulses
  wr_event_decode u_decode (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .mst_req_i (mst_req_i),
    .slv_rsp_i (slv_rsp_i),
    .evt_o     (evt)
  );

  wr_txn_tracker #(
    .MaxTxns (MaxTxns)
  ) u_tracker (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .evt_i         (evt),
    .budget_i      (budget_i),
    .flush_i       (flush),
    .timeout_o     (timeout),
    .outstanding_o (outstanding),
    .overflow_o    (overflow)
  );

  // Reset request and status towards the system
  wr_timeout_handler u_handler (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .timeout_i     (timeout),
    .reset_clear_i (reset_clear_i),
    .outstanding_i (outstanding),
    .overflow_i    (overflow),
    .flush_o       (flush),
    .reset_req_o   (reset_req_o),
    .irq_o         (irq_o),
    .status_o      (status_o)
  );

endmodule

// ==== test/tb_write_guard_tasks.svh ====
// Bus driver tasks, reset request wait and the directed tests of the write guard

  // Inputs change 1 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #1;
    // Any interrupt inside a test is remembered
    if (irq) begin
      irq_seen = 1'b1;
    end
  endtask

  task automatic drive_aw(input int id, input int len, input int wait_cycles);
    req.aw_valid = 1'b1;
    req.aw_id    = id_t'(id);
    req.aw_len   = len_t'(len);
    rsp.aw_ready = 1'b0;
    repeat (wait_cycles) step_cycle();
    rsp.aw_ready = 1'b1;
    step_cycle();
    req.aw_valid = 1'b0;
    rsp.aw_ready = 1'b0;
  endtask

  // Sends the first beats of a burst of len+1 beats
  task automatic drive_w_burst(input int len, input int gap, input int beats);
    for (int b = 0; b < beats; b++) begin
      req.w_valid  = 1'b1;
      req.w_last   = (b == len);
      rsp.w_ready  = 1'b1;
      step_cycle();
      req.w_valid  = 1'b0;
      req.w_last   = 1'b0;
      rsp.w_ready  = 1'b0;
      repeat (gap) step_cycle();
    end
  endtask

  task automatic drive_b(input int id, input int wait_cycles);
    repeat (wait_cycles) step_cycle();
    rsp.b_valid = 1'b1;
    rsp.b_id    = id_t'(id);
    req.b_ready = 1'b1;
    step_cycle();
    rsp.b_valid = 1'b0;
    req.b_ready = 1'b0;
  endtask

  task automatic wait_reset_req(input int limit, output int cycles);
    cycles = 0;
    while (!reset_req && cycles < limit) begin
      step_cycle();
      cycles++;
    end
    if (!reset_req) begin
      $display("Test %s timed out after %0d cycles waiting for the reset request",
               test_name, limit);
      test_errors++;
    end
  endtask

  task automatic check_record(input phase_e phase, input int id, input int count);
    check_value("irq", 32'd1, 32'(irq));
    check_value("last phase", 32'(phase), 32'(status.last_phase));
    check_value("last id", 32'(id), 32'(status.last_id));
    check_value("timeout count", 32'(count), 32'(status.timeout_cnt));
  endtask

  task automatic pulse_reset_clear();
    reset_clear = 1'b1;
    step_cycle();
    reset_clear = 1'b0;
    check_value("reset_req after clear", 32'd0, 32'(reset_req));
    repeat (2) step_cycle();
    check_value("outstanding after clear", 32'd0, 32'(status.outstanding));
  endtask

  task automatic check_after_reset();
    start_test("after_reset");
    check_value("reset_req", 32'd0, 32'(reset_req));
    check_value("irq", 32'd0, 32'(irq));
    check_value("outstanding", 32'd0, 32'(status.outstanding));
    check_value("timeout count", 32'd0, 32'(status.timeout_cnt));
    check_value("overflow", 32'd0, 32'(status.overflow));
    finish_test();
  endtask

  task automatic run_single_write();
    int id;
    id = int'(next_rand() % 16);
    start_test("single_write");
    drive_aw(id, 3, 2);
    check_value("outstanding mid", 32'd1, 32'(status.outstanding));
    drive_w_burst(3, 1, 4);
    check_value("outstanding before B", 32'd1, 32'(status.outstanding));
    drive_b(id, 3);
    repeat (2) step_cycle();
    check_value("outstanding end", 32'd0, 32'(status.outstanding));
    check_value("irq seen", 32'd0, 32'(irq_seen));
    check_value("timeout count", 32'd0, 32'(status.timeout_cnt));
    finish_test();
  endtask

  task automatic stall_aw();
    int id;
    int cycles;
    id = int'(next_rand() % 16);
    start_test("aw_stall");
    req.aw_valid = 1'b1;
    req.aw_id    = id_t'(id);
    req.aw_len   = len_t'(0);
    rsp.aw_ready = 1'b0;
    wait_reset_req(BudgetAw + 8, cycles);
    // Must not fire before the AW budget has run out
    check_value("not early", 32'd1, 32'(cycles >= BudgetAw));
    check_record(PH_AW, id, 1);
    req.aw_valid = 1'b0;
    step_cycle();
    pulse_reset_clear();
    finish_test();
  endtask

  task automatic scale_w_budget();
    int id;
    int cycles;
    start_test("w_scaling");
    // 8 beats at 3 cycles each stay under 8 budget units
    id = int'(next_rand() % 16);
    drive_aw(id, 7, 0);
    drive_w_burst(7, 2, 8);
    drive_b(id, 1);
    repeat (2) step_cycle();
    check_value("irq seen", 32'd0, 32'(irq_seen));
    check_value("outstanding", 32'd0, 32'(status.outstanding));
    check_value("timeout count", 32'd1, 32'(status.timeout_cnt));
    // Burst stalls before w_last
    id = int'(next_rand() % 16);
    drive_aw(id, 7, 0);
    drive_w_burst(7, 1, 3);
    wait_reset_req(BudgetWUnit * 8 + 8, cycles);
    check_record(PH_W, id, 2);
    pulse_reset_clear();
    finish_test();
  endtask

  task automatic stall_b();
    int id;
    int cycles;
    id = int'(next_rand() % 16);
    start_test("b_stall");
    drive_aw(id, 1, 1);
    drive_w_burst(1, 0, 2);
    wait_reset_req(BudgetB + 8, cycles);
    check_record(PH_B, id, 3);
    pulse_reset_clear();
    finish_test();
  endtask

  task automatic run_concurrent();
    int base;
    int ids[4];
    int len;
    start_test("concurrent");
    base = int'(next_rand() % 16);
    for (int i = 0; i < 4; i++) begin
      ids[i] = (base + i) % 16;
      len    = int'(next_rand() % 4);
      drive_aw(ids[i], len, int'(next_rand() % 3));
      drive_w_burst(len, 0, len + 1);
    end
    repeat (2) step_cycle();
    check_value("outstanding full", 32'd4, 32'(status.outstanding));
    // Responses come back out of order
    for (int i = 3; i >= 0; i--) begin
      drive_b(ids[i], int'(next_rand() % 2));
    end
    repeat (2) step_cycle();
    check_value("outstanding drained", 32'd0, 32'(status.outstanding));
    check_value("irq seen", 32'd0, 32'(irq_seen));
    check_value("timeout count", 32'd3, 32'(status.timeout_cnt));
    // Fifth AW finds the table full
    for (int i = 0; i < 5; i++) begin
      drive_aw(i, 7, 0);
    end
    repeat (2) step_cycle();
    check_value("outstanding capped", 32'd4, 32'(status.outstanding));
    check_value("overflow", 32'd1, 32'(status.overflow));
    check_value("irq seen", 32'd0, 32'(irq_seen));
    finish_test();
  endtask

// ==== test/tb_write_guard.sv ====
// Write guard testbench: clock, reset, DUT instance, LCG, check task and test sequence
`timescale 1ns/1ps

module tb_write_guard;
  import wr_guard_pkg::*;

  localparam int BudgetAw    = 10;
  localparam int BudgetWUnit = 4;
  localparam int BudgetB     = 48;

  logic          clk;
  logic          rst_n;
  wr_req_t       req;
  wr_rsp_t       rsp;
  budget_cfg_t   budget;
  logic          reset_clear;
  logic          reset_req;
  logic          irq;
  guard_status_t status;

  logic [31:0]   rand_state;
  string         test_name;
  int            test_errors;
  int            error_count;
  int            test_count;
  // Interrupt seen anywhere inside a test
  logic          irq_seen;

  write_guard #(
    .MaxTxns (4)
  ) dut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .mst_req_i     (req),
    .slv_rsp_i     (rsp),
    .budget_i      (budget),
    .reset_clear_i (reset_clear),
    .reset_req_o   (reset_req),
    .irq_o         (irq),
    .status_o      (status)
  );

  initial begin
    clk = 1'b0;
  end

  always #50 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    // Upper half has the better period
    return {16'd0, rand_state[31:16]};
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s %s expected 0x%0h actual 0x%0h",
               test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    irq_seen    = 1'b0;
  endtask

  task automatic finish_test();
    test_count++;
    error_count += test_errors;
    if (test_errors == 0) begin
      $display("PASS %s", test_name);
    end else begin
      $display("FAIL %s with %0d errors", test_name, test_errors);
    end
  endtask

  `include "tb_write_guard_tasks.svh"

  initial begin
    rand_state           = 32'hfd0f6717;
    req                  = '0;
    rsp                  = '0;
    reset_clear          = 1'b0;
    rst_n                = 1'b0;
    budget.budget_aw     = cnt_t'(BudgetAw);
    budget.budget_w_unit = cnt_t'(BudgetWUnit);
    budget.budget_b      = cnt_t'(BudgetB);
    test_name            = "none";
    test_errors          = 0;
    error_count          = 0;
    test_count           = 0;
    irq_seen             = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    check_after_reset();
    run_single_write();
    stall_aw();
    scale_w_budget();
    stall_b();
    run_concurrent();

    $display("Tests run: %0d, errors: %0d", test_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== wr_guard.f ====
+incdir+test
source/wr_guard_pkg.sv
source/wr_event_decode.sv
source/wr_txn_tracker.sv
source/wr_timeout_handler.sv
source/write_guard.sv
test/tb_write_guard.sv

// ==== Makefile ====
# Verilator build and run for the write guard testbench

VERILATOR ?= verilator
TOP       ?= tb_write_guard
FILELIST  ?= wr_guard.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(wildcard source/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, the simulator exit code alone is not enough
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
